/* source/acq_cfg_pkg.sv */
package acq_cfg_pkg;

    ////////////////////////////////////////
    // configuration vector types

    typedef logic [2:0]  cfg_addr_t;        // register address
    typedef logic [31:0] cfg_data_t;        // register write data
    typedef logic [11:0] chan_tag_t;        // channel tag, goes into both headers
    typedef logic [1:0]  fill_type_t;       // fill type from the acq enable pins
    typedef logic [13:0] burst_cnt_t;       // 8-sample bursts per waveform
    typedef logic [15:0] pre_trig_t;        // pre-trigger count in adc pairs
    typedef logic [22:0] ddr_adr_t;         // ddr3 burst address, 8 words per burst
    typedef logic [23:0] fill_num_t;        // running fill number

    ////////////////////////////////////////
    // register map

    localparam cfg_addr_t cfg_adr_tag     = 3'd0;   // channel tag
    localparam cfg_addr_t cfg_adr_type    = 3'd1;   // fill type
    localparam cfg_addr_t cfg_adr_bursts  = 3'd2;   // bursts per waveform
    localparam cfg_addr_t cfg_adr_pretrig = 3'd3;   // pre-trigger count
    localparam cfg_addr_t cfg_adr_base    = 3'd4;   // base address, restarts chain

    // addresses 5 to 7 are unused, writes there are dropped

endpackage

/* source/acq_rec_pkg.sv */
package acq_rec_pkg;

    ////////////////////////////////////////
    // record word types

    typedef logic [131:0] rec_word_t;       // tag plus payload, one fifo word
    typedef logic [127:0] payload_t;        // payload, also the checksum width
    typedef logic [25:0]  adc_pair_t;       // {smp1, ovr1, smp0, ovr0}
    typedef logic [3:0]   alarm_t;          // xadc alarm bits

    ////////////////////////////////////////
    // content tags, top nibble of each word

    localparam logic [3:0] tag_fill_hdr = 4'd1;
    localparam logic [3:0] tag_wave_hdr = 4'd2;
    localparam logic [3:0] tag_data     = 4'd3;
    localparam logic [3:0] tag_checksum = 4'd4;

    // header marker in payload bits 127:126
    // sign-extended data only ever has 00 or 11 there
    localparam logic [1:0] hdr_mark = 2'b01;

    // bit 0 is the format bit (26), bit 1 the cbuf flag (103)
    localparam logic [1:0] fill_fmt_cbuf = 2'b10;

    // fill header, waveform header and checksum
    localparam int unsigned rec_overhead = 3;

    ////////////////////////////////////////
    // sequencer states

    typedef enum logic [2:0] {
        s_idle,                             // waiting for fill_start
        s_fill_hdr,                         // one cycle, fill header
        s_wave_hdr,                         // one cycle, waveform header
        s_data,                             // one burst per adc_valid
        s_checksum                          // one cycle, checksum word
    } seq_state_t;

endpackage

/* source/acq_cfg_regs.sv */
`timescale 1ns/1ps

module acq_cfg_regs (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cfg_wr,         // one-cycle write strobe
    input  acq_cfg_pkg::cfg_addr_t  cfg_addr,
    input  acq_cfg_pkg::cfg_data_t  cfg_wdata,
    output acq_cfg_pkg::chan_tag_t  chan_tag,
    output acq_cfg_pkg::fill_type_t fill_type,
    output acq_cfg_pkg::burst_cnt_t num_bursts,
    output acq_cfg_pkg::pre_trig_t  pre_trig,
    output acq_cfg_pkg::ddr_adr_t   base_adr,
    output logic                    base_load       // pulse, new base in place
);

    ////////////////////////////////////////
    // write decode

    logic wr_tag;
    logic wr_type;
    logic wr_bursts;
    logic wr_pretrig;
    logic wr_base;

    assign wr_tag     = cfg_wr && (cfg_addr == acq_cfg_pkg::cfg_adr_tag);
    assign wr_type    = cfg_wr && (cfg_addr == acq_cfg_pkg::cfg_adr_type);
    assign wr_bursts  = cfg_wr && (cfg_addr == acq_cfg_pkg::cfg_adr_bursts);
    assign wr_pretrig = cfg_wr && (cfg_addr == acq_cfg_pkg::cfg_adr_pretrig);
    assign wr_base    = cfg_wr && (cfg_addr == acq_cfg_pkg::cfg_adr_base);

    ////////////////////////////////////////
    // configuration registers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chan_tag   <= '0;
            fill_type  <= '0;
            num_bursts <= '0;
            pre_trig   <= '0;
            base_adr   <= '0;
            base_load  <= 1'b0;
        end else begin
            if (wr_tag)
                chan_tag <= cfg_wdata[11:0];        // low bits only
            if (wr_type)
                fill_type <= cfg_wdata[1:0];
            if (wr_bursts)
                num_bursts <= cfg_wdata[13:0];      // zero means headers and checksum only
            if (wr_pretrig)
                pre_trig <= cfg_wdata[15:0];
            if (wr_base)
                base_adr <= cfg_wdata[22:0];
            // same edge as base_adr, so the sequencer sees the new value with it
            base_load <= wr_base;
        end
    end

endmodule

/* source/acq_sequencer.sv */
`timescale 1ns/1ps

module acq_sequencer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    fill_start,     // pulse, taken only when idle
    input  logic                    adc_valid,      // fresh burst on dat0..dat3
    input  acq_cfg_pkg::burst_cnt_t num_bursts,
    input  acq_cfg_pkg::ddr_adr_t   base_adr,
    input  logic                    base_load,
    output logic                    sel_fill_hdr,
    output logic                    sel_wave_hdr,
    output logic                    sel_dat,
    output logic                    sel_checksum,
    output acq_cfg_pkg::fill_num_t  fill_num,
    output acq_cfg_pkg::ddr_adr_t   burst_adr,      // fill header address
    output acq_cfg_pkg::ddr_adr_t   wave_adr,       // first waveform burst
    output logic                    busy
);

    acq_rec_pkg::seq_state_t state;
    acq_rec_pkg::seq_state_t state_nxt;
    acq_cfg_pkg::burst_cnt_t burst_cnt;         // accepted data bursts this fill
    acq_cfg_pkg::ddr_adr_t   next_adr;          // start of the next fill
    logic                    chk_out;           // checksum word on the output now
    logic                    start_ok;
    logic                    last_burst;

    assign start_ok   = fill_start && (state == acq_rec_pkg::s_idle) && !chk_out;
    assign last_burst = (burst_cnt == num_bursts - acq_cfg_pkg::burst_cnt_t'(1));

    ////////////////////////////////////////
    // fill state machine

    always_comb begin
        state_nxt = state;
        case (state)
            acq_rec_pkg::s_idle: begin
                if (start_ok)
                    state_nxt = acq_rec_pkg::s_fill_hdr;
            end
            acq_rec_pkg::s_fill_hdr: begin
                state_nxt = acq_rec_pkg::s_wave_hdr;
            end
            acq_rec_pkg::s_wave_hdr: begin
                if (num_bursts == '0)
                    state_nxt = acq_rec_pkg::s_checksum;    // empty waveform
                else
                    state_nxt = acq_rec_pkg::s_data;
            end
            acq_rec_pkg::s_data: begin
                if (adc_valid && last_burst)
                    state_nxt = acq_rec_pkg::s_checksum;
            end
            acq_rec_pkg::s_checksum: begin
                state_nxt = acq_rec_pkg::s_idle;
            end
            default: begin
                state_nxt = acq_rec_pkg::s_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= acq_rec_pkg::s_idle;
            chk_out <= 1'b0;
        end else begin
            state   <= state_nxt;
            chk_out <= sel_checksum;                // mux registers it, one cycle late
        end
    end

    // selects decode straight from state, dat also needs a burst present
    assign sel_fill_hdr = (state == acq_rec_pkg::s_fill_hdr);
    assign sel_wave_hdr = (state == acq_rec_pkg::s_wave_hdr);
    assign sel_dat      = (state == acq_rec_pkg::s_data) && adc_valid;
    assign sel_checksum = (state == acq_rec_pkg::s_checksum);

    // held through the cycle the checksum word leaves the mux
    assign busy = (state != acq_rec_pkg::s_idle) || chk_out;

    ////////////////////////////////////////
    // burst counter, fill counter, addresses

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            burst_cnt <= '0;
            fill_num  <= '0;
            next_adr  <= '0;
        end else begin
            if (sel_wave_hdr)
                burst_cnt <= '0;                    // clear just before the data
            else if (sel_dat)
                burst_cnt <= burst_cnt + acq_cfg_pkg::burst_cnt_t'(1);

            if (sel_checksum)
                fill_num <= fill_num + acq_cfg_pkg::fill_num_t'(1);

            if (base_load)
                next_adr <= base_adr;               // restart the chain
            else if (sel_checksum)
                next_adr <= next_adr + acq_cfg_pkg::ddr_adr_t'(num_bursts)
                          + acq_cfg_pkg::ddr_adr_t'(acq_rec_pkg::rec_overhead);
        end
    end

    assign burst_adr = next_adr;
    assign wave_adr  = next_adr + acq_cfg_pkg::ddr_adr_t'(1);  // past the fill header

    ////////////////////////////////////////
    // checks

    a_burst_room: assert property (@(posedge clk) disable iff (!arst_n)
        sel_dat |-> burst_cnt < num_bursts)
        else $error("data burst beyond num_bursts");

    a_burst_total: assert property (@(posedge clk) disable iff (!arst_n)
        sel_checksum |-> burst_cnt == num_bursts)
        else $error("checksum before all data bursts were taken");

endmodule

/* source/acq_burst_mux.sv */
`timescale 1ns/1ps

module acq_burst_mux (
    input  logic                    clk,
    input  logic                    arst_n,
    input  acq_rec_pkg::adc_pair_t  dat0,           // oldest pair
    input  acq_rec_pkg::adc_pair_t  dat1,
    input  acq_rec_pkg::adc_pair_t  dat2,
    input  acq_rec_pkg::adc_pair_t  dat3,           // newest pair
    input  acq_cfg_pkg::chan_tag_t  chan_tag,
    input  acq_cfg_pkg::fill_type_t fill_type,
    input  acq_cfg_pkg::burst_cnt_t num_bursts,
    input  acq_cfg_pkg::pre_trig_t  pre_trig,
    input  acq_cfg_pkg::fill_num_t  fill_num,
    input  acq_cfg_pkg::ddr_adr_t   burst_adr,
    input  acq_cfg_pkg::ddr_adr_t   wave_adr,
    input  acq_rec_pkg::alarm_t     xadc_alarms,
    input  logic                    sel_fill_hdr,
    input  logic                    sel_wave_hdr,
    input  logic                    sel_dat,
    input  logic                    sel_checksum,
    output acq_rec_pkg::rec_word_t  rec_data,
    output logic                    rec_valid
);

    acq_rec_pkg::payload_t  fill_pl;            // fill header payload
    acq_rec_pkg::payload_t  wave_pl;            // waveform header payload
    acq_rec_pkg::payload_t  data_pl;            // eight packed samples
    acq_rec_pkg::payload_t  chk;                // running xor
    acq_rec_pkg::alarm_t    alarms_q;           // frozen at the fill header
    acq_rec_pkg::adc_pair_t pairs [4];
    logic                   sel_any;

    assign sel_any = sel_fill_hdr || sel_wave_hdr || sel_dat || sel_checksum;

    ////////////////////////////////////////
    // fill header

    assign fill_pl[23:0]    = fill_num;
    assign fill_pl[25:24]   = fill_type;
    assign fill_pl[26]      = acq_rec_pkg::fill_fmt_cbuf[0];    // format bit, 0 for cbuf
    assign fill_pl[40:27]   = num_bursts;
    assign fill_pl[52:41]   = pre_trig[11:0];                   // pre-trigger low part
    assign fill_pl[75:53]   = burst_adr;
    assign fill_pl[98:76]   = 23'd1;                            // one waveform per cbuf fill
    assign fill_pl[102:99]  = pre_trig[15:12];                  // pre-trigger high part
    assign fill_pl[103]     = acq_rec_pkg::fill_fmt_cbuf[1];    // cbuf flag
    assign fill_pl[109:104] = '0;
    assign fill_pl[121:110] = chan_tag;
    assign fill_pl[125:122] = '0;
    assign fill_pl[127:126] = acq_rec_pkg::hdr_mark;

    ////////////////////////////////////////
    // waveform header

    assign wave_pl[13:0]    = num_bursts;
    assign wave_pl[25:14]   = pre_trig[11:0];
    assign wave_pl[51:26]   = {wave_adr, 3'b000};               // 16-bit word address
    assign wave_pl[74:52]   = '0;                               // waveform index, always 0 here
    assign wave_pl[97:75]   = '0;
    assign wave_pl[109:98]  = chan_tag;
    assign wave_pl[113:110] = alarms_q;
    assign wave_pl[125:114] = '0;
    assign wave_pl[127:126] = acq_rec_pkg::hdr_mark;

    ////////////////////////////////////////
    // data packing

    assign pairs[0] = dat0;
    assign pairs[1] = dat1;
    assign pairs[2] = dat2;
    assign pairs[3] = dat3;

    // drop the over-range bits, sign-extend 12 to 16 bits, oldest in the low word
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            data_pl[32*i +: 12]      = pairs[i][12:1];          // earlier sample
            data_pl[32*i + 12 +: 4]  = {4{pairs[i][12]}};
            data_pl[32*i + 16 +: 12] = pairs[i][25:14];         // later sample
            data_pl[32*i + 28 +: 4]  = {4{pairs[i][25]}};
        end
    end

    ////////////////////////////////////////
    // checksum and alarm latch

    always_ff @(posedge clk) begin
        if (sel_fill_hdr) begin
            chk      <= fill_pl;                    // seed with the fill header
            alarms_q <= xadc_alarms;                // stable for the header and checksum
        end else if (sel_wave_hdr) begin
            chk <= chk ^ wave_pl;
        end else if (sel_dat) begin
            chk <= chk ^ data_pl;
        end
    end

    ////////////////////////////////////////
    // output register

    always_ff @(posedge clk) begin
        if (sel_fill_hdr)
            rec_data <= {acq_rec_pkg::tag_fill_hdr, fill_pl};
        else if (sel_wave_hdr)
            rec_data <= {acq_rec_pkg::tag_wave_hdr, wave_pl};
        else if (sel_dat)
            rec_data <= {acq_rec_pkg::tag_data, data_pl};
        else if (sel_checksum)
            rec_data <= {acq_rec_pkg::tag_checksum, chk};   // covers every word before it
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            rec_valid <= 1'b0;
        else
            rec_valid <= sel_any;
    end

    // chk has taken in the waveform header and every burst before it leaves
    a_chk_after_payload: assert property (@(posedge clk) disable iff (!arst_n)
        sel_checksum |-> $past(sel_wave_hdr || sel_dat))
        else $error("checksum select not right after the waveform header or a burst");

endmodule

/* source/acq_channel_top.sv */
`timescale 1ns/1ps

module acq_channel_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cfg_wr,
    input  acq_cfg_pkg::cfg_addr_t  cfg_addr,
    input  acq_cfg_pkg::cfg_data_t  cfg_wdata,
    input  logic                    fill_start,
    input  logic                    adc_valid,
    input  acq_rec_pkg::adc_pair_t  dat0,
    input  acq_rec_pkg::adc_pair_t  dat1,
    input  acq_rec_pkg::adc_pair_t  dat2,
    input  acq_rec_pkg::adc_pair_t  dat3,
    input  acq_rec_pkg::alarm_t     xadc_alarms,
    output acq_rec_pkg::rec_word_t  rec_data,       // to the ddr3 write fifo
    output logic                    rec_valid,
    output logic                    busy
);

    ////////////////////////////////////////
    // internal wires

    acq_cfg_pkg::chan_tag_t  chan_tag;
    acq_cfg_pkg::fill_type_t fill_type;
    acq_cfg_pkg::burst_cnt_t num_bursts;
    acq_cfg_pkg::pre_trig_t  pre_trig;
    acq_cfg_pkg::ddr_adr_t   base_adr;
    logic                    base_load;
    logic                    sel_fill_hdr;
    logic                    sel_wave_hdr;
    logic                    sel_dat;
    logic                    sel_checksum;
    acq_cfg_pkg::fill_num_t  fill_num;
    acq_cfg_pkg::ddr_adr_t   burst_adr;
    acq_cfg_pkg::ddr_adr_t   wave_adr;

    acq_cfg_regs regs0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .chan_tag   (chan_tag),
        .fill_type  (fill_type),
        .num_bursts (num_bursts),
        .pre_trig   (pre_trig),
        .base_adr   (base_adr),
        .base_load  (base_load)
    );

    acq_sequencer seq0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .fill_start   (fill_start),
        .adc_valid    (adc_valid),
        .num_bursts   (num_bursts),
        .base_adr     (base_adr),
        .base_load    (base_load),
        .sel_fill_hdr (sel_fill_hdr),
        .sel_wave_hdr (sel_wave_hdr),
        .sel_dat      (sel_dat),
        .sel_checksum (sel_checksum),
        .fill_num     (fill_num),
        .burst_adr    (burst_adr),
        .wave_adr     (wave_adr),
        .busy         (busy)
    );

    acq_burst_mux mux0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .dat0         (dat0),
        .dat1         (dat1),
        .dat2         (dat2),
        .dat3         (dat3),
        .chan_tag     (chan_tag),
        .fill_type    (fill_type),
        .num_bursts   (num_bursts),
        .pre_trig     (pre_trig),
        .fill_num     (fill_num),
        .burst_adr    (burst_adr),
        .wave_adr     (wave_adr),
        .xadc_alarms  (xadc_alarms),
        .sel_fill_hdr (sel_fill_hdr),
        .sel_wave_hdr (sel_wave_hdr),
        .sel_dat      (sel_dat),
        .sel_checksum (sel_checksum),
        .rec_data     (rec_data),
        .rec_valid    (rec_valid)
    );

endmodule

/* tests/acq_channel_tb.sv */
`timescale 1ns/1ps

module acq_channel_tb;

    localparam int unsigned burst_sum   = 5 + 0 + 9 + 3;   // bursts over the four fills
    localparam int unsigned cycle_limit =
        4 * (burst_sum + 4 * acq_rec_pkg::rec_overhead) * 4 + 200;

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    cfg_wr;
    acq_cfg_pkg::cfg_addr_t  cfg_addr;
    acq_cfg_pkg::cfg_data_t  cfg_wdata;
    logic                    fill_start;
    logic                    adc_valid = 1'b0;
    acq_rec_pkg::adc_pair_t  dat0 = '0;
    acq_rec_pkg::adc_pair_t  dat1 = '0;
    acq_rec_pkg::adc_pair_t  dat2 = '0;
    acq_rec_pkg::adc_pair_t  dat3 = '0;
    acq_rec_pkg::alarm_t     xadc_alarms = '0;
    acq_rec_pkg::rec_word_t  rec_data;
    logic                    rec_valid;
    logic                    busy;

    logic [31:0]             lfsr = 32'haba9;
    logic [103:0]            dat_q;             // pairs held one edge back
    logic                    valid_q;
    acq_rec_pkg::alarm_t     alarm_q;
    acq_rec_pkg::alarm_t     exp_alarm;         // alarms taken with the fill header
    acq_cfg_pkg::chan_tag_t  m_tag;             // mirror of the register block
    acq_cfg_pkg::fill_type_t m_type;
    acq_cfg_pkg::burst_cnt_t m_bursts;
    acq_cfg_pkg::pre_trig_t  m_pretrig;
    acq_cfg_pkg::ddr_adr_t   exp_adr;           // address chain
    acq_cfg_pkg::fill_num_t  exp_fill_num;
    logic [3:0]              exp_tag;
    acq_cfg_pkg::burst_cnt_t data_seen;
    acq_rec_pkg::payload_t   chk_acc;           // xor of the payloads seen so far
    acq_rec_pkg::payload_t   exp_fill_pl;
    acq_rec_pkg::payload_t   exp_wave_pl;
    acq_rec_pkg::payload_t   pl;
    logic [3:0]              tag;
    logic                    in_fill;
    logic                    start_real;        // marks the fill_start that counts
    int                      fills_done;
    int                      err_cnt = 0;
    int                      err_mark = 0;
    int                      n_tests = 0;
    int                      cycles = 0;
    string                   cur_test = "reset";

    acq_channel_top dut0 (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];    // taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic acq_rec_pkg::payload_t pack_burst(input logic [103:0] pairs);
        acq_rec_pkg::payload_t p;
        logic [11:0]           s;
        for (int k = 0; k < 8; k++) begin
            s             = pairs[13*k + 1 +: 12];   // skip the over-range bit
            p[16*k +: 16] = {{4{s[11]}}, s};
        end
        return p;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("FAILED %s %s: expected %0h actual %0h", cur_test, what, exp, act);
        err_cnt++;
    endtask

    task automatic report_problem(input string what);
        $display("error in %s: %s", cur_test, what);
        err_cnt++;
    endtask

    task automatic end_test();
        $display("%-8s %s", cur_test, (err_cnt == err_mark) ? "ok" : "failed");
        n_tests++;
        err_mark = err_cnt;
    endtask

    task automatic write_reg(input acq_cfg_pkg::cfg_addr_t addr,
                             input acq_cfg_pkg::cfg_data_t data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    task automatic run_fill(input string name, input int unsigned bursts,
                            input logic new_base, input acq_cfg_pkg::ddr_adr_t base);
        int target;
        cur_test = name;
        target   = fills_done + 1;
        write_reg(acq_cfg_pkg::cfg_adr_bursts, 32'(bursts));
        if (new_base)
            write_reg(acq_cfg_pkg::cfg_adr_base, 32'(base));    // restarts the chain
        @(posedge clk);
        fill_start <= 1'b1;
        start_real <= 1'b1;
        @(posedge clk);
        fill_start <= 1'b0;
        start_real <= 1'b0;
        repeat (2) @(posedge clk);
        fill_start <= 1'b1;                     // lands while busy, must be dropped
        @(posedge clk);
        fill_start <= 1'b0;
        while (fills_done < target)
            @(posedge clk);
        repeat (8) @(posedge clk);              // room for a stray record to show up
        end_test();
    endtask

    ////////////////////////////////////////
    // adc and xadc stimulus

    always @(posedge clk) begin
        adc_valid   <= (take_bits(2) != 0);     // about one gap in four
        dat0        <= acq_rec_pkg::adc_pair_t'(take_bits(26));
        dat1        <= acq_rec_pkg::adc_pair_t'(take_bits(26));
        dat2        <= acq_rec_pkg::adc_pair_t'(take_bits(26));
        dat3        <= acq_rec_pkg::adc_pair_t'(take_bits(26));
        xadc_alarms <= acq_rec_pkg::alarm_t'(take_bits(4));
    end

    ////////////////////////////////////////
    // reference model

    assign tag = rec_data[131:128];
    assign pl  = rec_data[127:0];

    assign exp_fill_pl = {2'b01, 4'h0, m_tag, 6'h0, 1'b1, m_pretrig[15:12], 23'd1,
                          exp_adr, m_pretrig[11:0], m_bursts, 1'b0, m_type, exp_fill_num};
    assign exp_wave_pl = {2'b01, 12'h0, exp_alarm, m_tag, 46'h0, exp_adr + 23'd1, 3'b000,
                          m_pretrig[11:0], m_bursts};   // index field stays zero

    always @(posedge clk) begin
        dat_q   <= {dat3, dat2, dat1, dat0};
        valid_q <= adc_valid;
        alarm_q <= xadc_alarms;
        if (!arst_n) begin
            m_tag        <= '0;
            m_type       <= '0;
            m_bursts     <= '0;
            m_pretrig    <= '0;
            exp_adr      <= '0;
            exp_fill_num <= '0;
            exp_tag      <= acq_rec_pkg::tag_fill_hdr;
            in_fill      <= 1'b0;
            fills_done   <= 0;
        end else begin
            if (cfg_wr) begin
                case (cfg_addr)
                    acq_cfg_pkg::cfg_adr_tag:     m_tag     <= cfg_wdata[11:0];
                    acq_cfg_pkg::cfg_adr_type:    m_type    <= cfg_wdata[1:0];
                    acq_cfg_pkg::cfg_adr_bursts:  m_bursts  <= cfg_wdata[13:0];
                    acq_cfg_pkg::cfg_adr_pretrig: m_pretrig <= cfg_wdata[15:0];
                    acq_cfg_pkg::cfg_adr_base:    exp_adr   <= cfg_wdata[22:0];
                    default: ;                  // unused addresses change nothing
                endcase
            end
            if (fill_start && start_real)
                in_fill <= 1'b1;
            if (rec_valid) begin
                case (tag)
                    acq_rec_pkg::tag_fill_hdr: begin
                        chk_acc   <= pl;        // checksum starts over each fill
                        exp_alarm <= alarm_q;
                        exp_tag   <= acq_rec_pkg::tag_wave_hdr;
                    end
                    acq_rec_pkg::tag_wave_hdr: begin
                        chk_acc   <= chk_acc ^ pl;
                        data_seen <= '0;
                        exp_tag   <= (m_bursts == 0) ? acq_rec_pkg::tag_checksum
                                                     : acq_rec_pkg::tag_data;
                    end
                    acq_rec_pkg::tag_data: begin
                        chk_acc   <= chk_acc ^ pl;
                        data_seen <= data_seen + 1'b1;
                        if (data_seen + 1 == m_bursts)
                            exp_tag <= acq_rec_pkg::tag_checksum;
                    end
                    default: begin              // checksum closes the fill
                        exp_tag      <= acq_rec_pkg::tag_fill_hdr;
                        exp_fill_num <= exp_fill_num + 1'b1;
                        exp_adr      <= exp_adr + 23'(m_bursts) + 23'd3;   // wraps in 23 bits
                        in_fill      <= 1'b0;
                        fills_done   <= fills_done + 1;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // checks

    a_reset_idle: assert property (@(posedge clk) $rose(arst_n) |-> !rec_valid && !busy)
        else report_problem("rec_valid or busy high right after reset");

    a_order: assert property (@(posedge clk) disable iff (!arst_n)
        rec_valid |-> in_fill && tag == exp_tag)
        else begin
            if (!$sampled(in_fill))
                report_problem("record output while no fill was running");
            else
                report_mismatch("content tag", $sampled(exp_tag), $sampled(tag));
        end

    a_busy_rec: assert property (@(posedge clk) disable iff (!arst_n)
        rec_valid |-> busy)
        else report_problem("busy low while a record was output");

    a_busy_end: assert property (@(posedge clk) disable iff (!arst_n)
        rec_valid && tag == acq_rec_pkg::tag_checksum |=> !busy)
        else report_problem("busy still high after the checksum word");

    a_fill_hdr: assert property (@(posedge clk) disable iff (!arst_n)
        rec_valid && tag == acq_rec_pkg::tag_fill_hdr |-> pl == exp_fill_pl)
        else report_mismatch("fill header", $sampled(exp_fill_pl), $sampled(pl));

    a_wave_hdr: assert property (@(posedge clk) disable iff (!arst_n)
        rec_valid && tag == acq_rec_pkg::tag_wave_hdr |-> pl == exp_wave_pl)
        else report_mismatch("waveform header", $sampled(exp_wave_pl), $sampled(pl));

    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        rec_valid && tag == acq_rec_pkg::tag_data |-> valid_q && pl == pack_burst(dat_q))
        else begin
            if (!$sampled(valid_q))
                report_problem("data word without adc_valid the cycle before");
            else
                report_mismatch("data word", pack_burst($sampled(dat_q)), $sampled(pl));
        end

    a_checksum: assert property (@(posedge clk) disable iff (!arst_n)
        rec_valid && tag == acq_rec_pkg::tag_checksum |-> pl == chk_acc)
        else report_mismatch("checksum", $sampled(chk_acc), $sampled(pl));

    ////////////////////////////////////////
    // watchdog and test sequence

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        arst_n     = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        fill_start = 1'b0;
        start_real = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);              // reset check fires on the edge after release
        end_test();
        cur_test = "config";
        write_reg(acq_cfg_pkg::cfg_adr_tag, 32'hfff0_05a3);    // upper bits dropped
        write_reg(acq_cfg_pkg::cfg_adr_type, 32'd2);
        write_reg(acq_cfg_pkg::cfg_adr_pretrig, 32'h0001_b3c7);
        write_reg(3'd6, 32'hdead_beef);                         // unused address
        end_test();
        run_fill("fill_a", 5, 1'b0, '0);
        run_fill("fill_b", 0, 1'b0, '0);                        // headers and checksum only
        run_fill("fill_c", 9, 1'b1, 23'h7ffffa);
        run_fill("fill_d", 3, 1'b0, '0);                        // chain wraps past the top
        $display("tests %0d, errors %0d", n_tests, err_cnt);
        if (err_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
source/acq_cfg_pkg.sv
source/acq_rec_pkg.sv
source/acq_cfg_regs.sv
source/acq_sequencer.sv
source/acq_burst_mux.sv
source/acq_channel_top.sv
tests/acq_channel_tb.sv
